//--- project.f
rtl/axi_lite_pkg.sv
rtl/fetch_pkg.sv
rtl/pc_unit.sv
rtl/fetch_axi_master.sv
rtl/inst_sram.sv
rtl/fetch_buffer.sv
rtl/fetch_top.sv
tests/fetch_tb.sv

//--- rtl/axi_lite_pkg.sv
`default_nettype none

// axi4-lite read side only, instruction fetch never writes
package axi_lite_pkg;

    typedef logic [31:0] axi_addr_t;  // byte address
    typedef logic [31:0] axi_data_t;  // one bus word
    typedef logic [1:0]  axi_resp_t;

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;  // bad address or misaligned

    // prot[2] set marks an instruction access
    localparam logic [2:0] AXI_PROT_INST = 3'b100;

    // read address channel payload, arvalid/arready travel beside it
    typedef struct packed {
        axi_addr_t  addr;
        logic [2:0] prot;
    } axi_ar_t;

    // read data channel payload, rvalid/rready travel beside it
    typedef struct packed {
        axi_data_t data;
        axi_resp_t resp;
    } axi_r_t;

endpackage

`default_nettype wire

//--- rtl/fetch_axi_master.sv
`default_nettype none

// axi4-lite read master, one fetch in flight at a time
module fetch_axi_master
    import axi_lite_pkg::*;
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  pc_t        pc,
    input  logic       kill,
    output logic       busy,
    output axi_ar_t    ar,
    output logic       arvalid,
    input  logic       arready,
    input  axi_r_t     r,
    input  logic       rvalid,
    output logic       rready,
    output logic       load,       // pulse into the buffer
    output fetch_out_t load_data,
    input  logic       full,
    input  logic       taken,      // decoder took the buffered word
    output logic       advance
);

    fetch_state_t state;
    fetch_state_t state_next;
    logic         stale;    // current fetch was killed, drop its word
    logic         ar_fire;
    logic         r_fire;
    logic         drop;

    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;
    assign drop    = stale || kill;  // kill may land on the r beat itself

    assign busy    = (state == ADDR) || (state == DATA);
    assign arvalid = (state == ADDR);
    assign rready  = (state == DATA);
    assign ar.addr = pc;             // pc only moves on redirect or advance
    assign ar.prot = AXI_PROT_INST;
    assign advance = taken && (state == HOLD);

    always_comb begin
        state_next = state;
        case (state)
            IDLE: state_next = ADDR;
            ADDR: if (ar_fire) state_next = DATA;
            DATA: if (r_fire) state_next = drop ? IDLE : HOLD;
            // leave once the buffer drains, either taken or flushed
            HOLD: if (taken || (!full && !load)) state_next = ADDR;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            stale <= 1'b0;
            load  <= 1'b0;
        end else begin
            state <= state_next;
            load  <= r_fire && !drop;  // good word goes to the buffer next cycle
            if (r_fire) begin
                stale <= 1'b0;         // fetch finished on the bus
            end else if (kill) begin
                stale <= 1'b1;
            end
        end
    end

    // payload, pc still matches the request unless the fetch is stale
    always_ff @(posedge clk) begin
        if (r_fire) begin
            load_data.pc    <= pc;
            load_data.inst  <= r.data;
            load_data.fault <= (r.resp != RESP_OKAY);
        end
    end

    // request held steady until the slave accepts it
    a_ar_hold: assert property (
        @(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(ar)
    );

    // buffer has a single slot
    a_load_empty: assert property (
        @(posedge clk) disable iff (rst)
        load |-> !full
    );

endmodule

`default_nettype wire

//--- rtl/fetch_buffer.sv
`default_nettype none

// one-entry holding register in front of the decoder
module fetch_buffer
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       load,
    input  fetch_out_t load_data,
    input  logic       flush,       // redirect, drop whatever sits here
    input  logic       inst_ready,
    output logic       inst_valid,
    output fetch_out_t inst_out,
    output logic       full,
    output logic       taken
);

    assign inst_valid = full;
    assign taken      = full && inst_ready;  // decoder handshake

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (flush) begin
            full <= 1'b0;  // beats a load in the same cycle, that word is old path
        end else if (load) begin
            full <= 1'b1;
        end else if (taken) begin
            full <= 1'b0;
        end
    end

    // load only arrives while empty, so held data never changes under valid
    always_ff @(posedge clk) begin
        if (load) begin
            inst_out <= load_data;
        end
    end

endmodule

`default_nettype wire

//--- rtl/fetch_pkg.sv
`default_nettype none

// fetch side types, memory map and master states
package fetch_pkg;

    typedef logic [31:0] pc_t;
    typedef logic [31:0] inst_t;

    // decoder port payload, 65 bits
    typedef struct packed {
        pc_t   pc;
        inst_t inst;
        logic  fault;  // bus error on this fetch
    } fetch_out_t;

    localparam pc_t RESET_PC = 32'h8000_0000;  // reset vector
    localparam pc_t PC_STEP  = 32'd4;          // one word per instruction

    // instruction memory map
    localparam pc_t         IMEM_BASE  = 32'h8000_0000;
    localparam int unsigned IMEM_DEPTH = 16;                 // words
    localparam int unsigned IMEM_BYTES = 4 * IMEM_DEPTH;
    localparam int unsigned IMEM_AW    = $clog2(IMEM_DEPTH); // word index width
    localparam string       IMEM_FILE  = "tests/inst.hex";

    // master fsm
    typedef enum logic [1:0] {
        IDLE,  // pick up pc, after reset or a dropped fetch
        ADDR,  // arvalid up
        DATA,  // rready up, waiting on the word
        HOLD   // word handed to the buffer, wait for it to drain
    } fetch_state_t;

endpackage

`default_nettype wire

//--- rtl/fetch_top.sv
`default_nettype none

// instruction fetch: pc -> axi master -> sram, word out through the buffer
module fetch_top
    import axi_lite_pkg::*;
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       redirect_valid,
    input  pc_t        redirect_pc,
    output logic       inst_valid,
    input  logic       inst_ready,
    output fetch_out_t inst_out
);

    pc_t        pc;
    logic       kill;
    logic       busy;
    logic       advance;
    axi_ar_t    ar;
    logic       arvalid;
    logic       arready;
    axi_r_t     r;
    logic       rvalid;
    logic       rready;
    logic       load;
    fetch_out_t load_data;
    logic       full;
    logic       taken;

    pc_unit u_pc (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .advance        (advance),
        .busy           (busy),
        .pc             (pc),
        .kill           (kill)
    );

    fetch_axi_master u_master (
        .clk       (clk),
        .rst       (rst),
        .pc        (pc),
        .kill      (kill),
        .busy      (busy),
        .ar        (ar),
        .arvalid   (arvalid),
        .arready   (arready),
        .r         (r),
        .rvalid    (rvalid),
        .rready    (rready),
        .load      (load),
        .load_data (load_data),
        .full      (full),
        .taken     (taken),
        .advance   (advance)
    );

    inst_sram u_sram (
        .clk     (clk),
        .rst     (rst),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .r       (r),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    // redirect pulse doubles as the buffer flush
    fetch_buffer u_buffer (
        .clk        (clk),
        .rst        (rst),
        .load       (load),
        .load_data  (load_data),
        .flush      (redirect_valid),
        .inst_ready (inst_ready),
        .inst_valid (inst_valid),
        .inst_out   (inst_out),
        .full       (full),
        .taken      (taken)
    );

endmodule

`default_nettype wire

//--- rtl/inst_sram.sv
`default_nettype none

// read-only axi4-lite slave over the instruction array
module inst_sram
    import axi_lite_pkg::*;
    import fetch_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  axi_ar_t ar,
    input  logic    arvalid,
    output logic    arready,
    output axi_r_t  r,
    output logic    rvalid,
    input  logic    rready
);

    inst_t              mem [IMEM_DEPTH];
    axi_addr_t          raddr;   // address of the pending read
    axi_addr_t          offset;  // byte offset from the base
    logic [IMEM_AW-1:0] idx;
    logic               hit;     // in range and word aligned
    logic               ar_fire;
    logic               r_fire;

    initial begin
        $readmemh(IMEM_FILE, mem);  // program image
    end

    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;

    // one read at a time, arready comes back once the word is taken
    always_ff @(posedge clk) begin
        if (rst) begin
            arready <= 1'b1;
            rvalid  <= 1'b0;
        end else if (ar_fire) begin
            arready <= 1'b0;
            rvalid  <= 1'b1;  // latency of one
        end else if (r_fire) begin
            arready <= 1'b1;
            rvalid  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            raddr <= ar.addr;
        end
    end

    assign offset = raddr - IMEM_BASE;
    assign idx    = offset[IMEM_AW+1:2];
    assign hit    = (raddr >= IMEM_BASE) && (offset < IMEM_BYTES) && (raddr[1:0] == 2'b00);

    // word read straight from the latched address, stays put until rready
    always_comb begin
        if (hit) begin
            r.data = mem[idx];
            r.resp = RESP_OKAY;
        end else begin
            r.data = '0;  // error beats return zero
            r.resp = RESP_SLVERR;
        end
    end

    // response held while the master stalls
    a_r_stable: assert property (
        @(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(r)
    );

endmodule

`default_nettype wire

//--- rtl/pc_unit.sv
`default_nettype none

// fetch pc: sequential step, redirect load, kill of an outstanding fetch
module pc_unit
    import fetch_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic redirect_valid,  // one-cycle pulse
    input  pc_t  redirect_pc,
    input  logic advance,         // buffer took a good instruction
    input  logic busy,            // master has a fetch on the bus
    output pc_t  pc,
    output logic kill
);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (redirect_valid) begin  // redirect wins over advance
            pc <= redirect_pc;
        end else if (advance) begin
            pc <= pc + PC_STEP;
        end
    end

    // fetch on the bus belongs to the old path
    // combinational so a response landing this same cycle is dropped too
    assign kill = redirect_valid && busy;

    // advance only comes from HOLD, kill only from ADDR/DATA
    a_kill_no_advance: assert property (
        @(posedge clk) disable iff (rst)
        kill |-> !advance
    );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the instruction fetch testbench with verilator
set -e
cd "$(dirname "$0")"

# rtl has no timeunit of its own, the default covers it
verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module fetch_tb \
    -f project.f \
    -o fetch_sim

# program image path is relative to the project root
out=$(./obj_dir/fetch_sim)
echo "$out"
echo "$out" | grep -qF "All tests passed!"

//--- tests/fetch_tb.sv
`default_nettype none

module fetch_tb
    import fetch_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 2000;  // tests need roughly 500

    logic       clk;
    logic       rst;
    logic       redirect_valid;
    pc_t        redirect_pc;
    logic       inst_valid;
    logic       inst_ready;
    fetch_out_t inst_out;

    inst_t  ref_mem [IMEM_DEPTH];  // own copy of the program image
    integer seed;
    int     errors = 0;
    int     checks = 0;
    int     cycle_count = 0;

    fetch_top dut_i (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .inst_valid     (inst_valid),
        .inst_ready     (inst_ready),
        .inst_out       (inst_out)
    );

    always #5 clk = ~clk;  // 10 ns period

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycle_count);
            $display("Test failures found");
            $finish;
        end
    end

    // memory map rule, word from the image or a bus error with zero
    function automatic fetch_out_t expected_fetch(pc_t pc);
        fetch_out_t         exp;
        logic [IMEM_AW-1:0] word_idx;
        word_idx = IMEM_AW'((pc - IMEM_BASE) >> 2);
        exp.pc   = pc;
        if (pc >= IMEM_BASE && pc < IMEM_BASE + 4 * IMEM_DEPTH && pc[1:0] == 2'b00) begin
            exp.inst  = ref_mem[word_idx];
            exp.fault = 1'b0;
        end else begin
            exp.inst  = '0;
            exp.fault = 1'b1;
        end
        return exp;
    endfunction

    task automatic check_fetch(input string name, input fetch_out_t got, input pc_t exp_pc);
        fetch_out_t exp;
        exp = expected_fetch(exp_pc);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: expected pc %h inst %h fault %b, got pc %h inst %h fault %b",
                     name, exp.pc, exp.inst, exp.fault, got.pc, got.inst, got.fault);
        end
    endtask

    task automatic check_count(input string name, input string what, input int exp, input int act);
        checks++;
        if (exp != act) begin
            errors++;
            $display("FAILED %s: %s expected %0d, got %0d", name, what, exp, act);
        end
    endtask

    task automatic report_problem(input string name, input string msg);
        errors++;
        $display("ERROR in %s: %s", name, msg);
    endtask

    // waits for the handshake, returns with the take edge just passed
    task automatic take_inst(output fetch_out_t got, output int waited);
        logic done;
        done   = 1'b0;
        waited = 0;
        got    = '0;
        while (!done) begin
            @(negedge clk);  // outputs settled here
            waited++;
            if (inst_valid && inst_ready) begin
                got  = inst_out;
                done = 1'b1;
            end
        end
        @(posedge clk);
    endtask

    // one-cycle pulse, caller sits just after a rising edge
    task automatic send_redirect(input string name, input pc_t target, input bit in_flight);
        redirect_valid <= 1'b1;
        redirect_pc    <= target;
        @(negedge clk);
        if (in_flight) begin
            checks++;
            if (!dut_i.kill) report_problem(name, "redirect did not meet an outstanding fetch");
        end
        @(posedge clk);
        redirect_valid <= 1'b0;
    endtask

    task automatic test_reset_stream();
        fetch_out_t got;
        int         waited;
        int         n;
        int         i;
        inst_ready <= 1'b1;
        @(negedge clk);
        checks++;
        if (inst_valid) report_problem("test_reset_stream", "inst_valid high right after reset");
        n = 0;
        while (!inst_valid) begin
            @(posedge clk);
            n++;
            @(negedge clk);
        end
        check_count("test_reset_stream", "cycles to first instruction", 4, n);
        got = inst_out;
        @(posedge clk);  // first one taken here
        check_fetch("test_reset_stream", got, RESET_PC);
        for (i = 1; i < 8; i++) begin
            take_inst(got, waited);
            check_fetch("test_reset_stream", got, RESET_PC + pc_t'(4 * i));
            check_count("test_reset_stream", "cycles between instructions", 4, waited);
        end
    endtask

    task automatic test_backpressure();
        fetch_out_t got;
        fetch_out_t held;
        bit         have_held;
        int         waited;
        int         stall;
        int         i;
        int         k;
        pc_t        exp_pc;
        exp_pc = RESET_PC + 32'h20;  // stream goes on from the first test
        held   = '0;
        for (i = 0; i < 8; i++) begin
            stall     = $random(seed) & 7;
            have_held = 1'b0;
            inst_ready <= 1'b0;
            for (k = 0; k < stall; k++) begin
                @(negedge clk);
                checks++;
                if (have_held && !inst_valid) begin
                    report_problem("test_backpressure", "inst_valid dropped before the take");
                end else if (have_held && inst_out !== held) begin
                    report_problem("test_backpressure", "inst_out changed while stalled");
                end
                if (inst_valid) begin
                    held      = inst_out;
                    have_held = 1'b1;
                end
                @(posedge clk);
            end
            inst_ready <= 1'b1;
            take_inst(got, waited);
            if (have_held && got !== held) begin
                report_problem("test_backpressure", "instruction changed when inst_ready rose");
            end
            check_fetch("test_backpressure", got, exp_pc);  // no gap, no repeat
            exp_pc = exp_pc + 32'd4;
        end
    endtask

    task automatic test_redirect();
        fetch_out_t got;
        int         waited;
        int         i;
        inst_ready <= 1'b0;
        repeat (6) @(posedge clk);  // chain stalls with a word sitting in the buffer
        send_redirect("test_redirect", RESET_PC + 32'h20, 1'b0);
        inst_ready <= 1'b1;
        @(negedge clk);
        checks++;
        if (inst_valid) report_problem("test_redirect", "old instruction still valid after flush");
        @(posedge clk);
        for (i = 0; i < 4; i++) begin
            take_inst(got, waited);
            check_fetch("test_redirect", got, RESET_PC + pc_t'(32'h20 + 4 * i));
        end
    endtask

    task automatic test_redirect_in_flight();
        fetch_out_t got;
        int         waited;
        int         i;
        take_inst(got, waited);
        check_fetch("test_redirect_in_flight", got, RESET_PC + 32'h30);
        // master enters ADDR on this edge
        send_redirect("test_redirect_in_flight", RESET_PC + 32'h08, 1'b1);
        for (i = 0; i < 3; i++) begin
            take_inst(got, waited);
            check_fetch("test_redirect_in_flight", got, RESET_PC + pc_t'(32'h08 + 4 * i));
        end
        @(posedge clk);  // now the r beat is on the bus
        send_redirect("test_redirect_in_flight", RESET_PC + 32'h30, 1'b1);
        for (i = 0; i < 2; i++) begin
            take_inst(got, waited);
            check_fetch("test_redirect_in_flight", got, RESET_PC + pc_t'(32'h30 + 4 * i));
        end
    endtask

    task automatic test_fault();
        fetch_out_t got;
        int         waited;
        send_redirect("test_fault", RESET_PC + 32'h40, 1'b1);  // one past the array
        take_inst(got, waited);
        check_fetch("test_fault", got, RESET_PC + 32'h40);
        send_redirect("test_fault", RESET_PC + 32'h02, 1'b1);  // misaligned
        take_inst(got, waited);
        check_fetch("test_fault", got, RESET_PC + 32'h02);
    endtask

    initial begin
        clk = 1'b0;
        rst            <= 1'b1;
        redirect_valid <= 1'b0;
        redirect_pc    <= '0;
        inst_ready     <= 1'b0;
        seed = 32'hb70e_29cd;
        $readmemh(IMEM_FILE, ref_mem);
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        test_reset_stream();
        test_backpressure();
        test_redirect();
        test_redirect_in_flight();
        test_fault();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/inst.hex
// one 32-bit instruction word per line, hex
// first line is the word at 0x8000_0000, then upward in steps of 4
00000013 // nop
00100093 // addi x1, x0, 1
00200113 // addi x2, x0, 2
002081b3 // add  x3, x1, x2
40208233 // sub  x4, x1, x2
0030f2b3
0030e333
0030c3b3
00119413
0011d493
00a00513 // addi x10, x0, 10
fff50513 // addi x10, x10, -1
fe051ee3 // loop back while x10 != 0
00008067
0000006f // spin
00100073 // ebreak
